// ==== all.f ====
design/bpredCfgPkg.sv
design/bpredTypesPkg.sv
design/bpredUpdateIf.sv
design/instrClassDecode.sv
design/dirCounterTable.sv
design/branchTargetBuffer.sv
design/returnAddrStack.sv
design/predResolve.sv
design/bpredTop.sv
tb/clockGen.sv
tb/bpredChecker.sv
tb/bpredTb.sv

// ==== Bender.yml ====
package:
  name: bpred

sources:
  - files:
      - design/bpredCfgPkg.sv
      - design/bpredTypesPkg.sv
      - design/bpredUpdateIf.sv
      - design/instrClassDecode.sv
      - design/dirCounterTable.sv
      - design/branchTargetBuffer.sv
      - design/returnAddrStack.sv
      - design/predResolve.sv
      - design/bpredTop.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/bpredChecker.sv
      - tb/bpredTb.sv

// ==== tb/bpredTb.sv ====
`timescale 1ns/1ps

module bpredTb;
  import bpredCfgPkg::*;
  import bpredTypesPkg::*;

  // Watchdog budget
  localparam int numIssues      = 40;
  localparam int cyclesPerIssue = 8;
  localparam int marginCycles   = 50;

  localparam instrT nopWord  = 32'h0000_0013;
  localparam instrT brWord   = 32'h0000_0063;
  localparam instrT jalWord  = 32'h0000_006F;
  // JALR through x5
  localparam instrT jalrWord = 32'h0002_8067;
  // JALR through x1
  localparam instrT retWord  = 32'h0000_8067;

  // How an instruction travels the pipeline
  localparam int modePlain   = 0;
  localparam int modeRefetch = 1;
  localparam int modeStall   = 2;
  localparam int modeFlush   = 3;

  logic  clk;
  logic  rstN;
  logic  stallF;
  logic  stallD;
  logic  flushF;
  logic  flushD;
  addrT  pcNextF;
  instrT instrF;
  addrT  pcD;
  addrT  pcE;
  addrT  pcTargetE;
  addrT  pcLinkE;
  logic  pcSrcE;
  addrT  predPcF;
  logic  selPredF;
  logic  predWrongE;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  dirStateT refCounter [2**dirIdxW];
  logic     refValid   [2**btbIdxW];
  // Full PC per entry, the tag is taken from it
  addrT     refPc      [2**btbIdxW];
  addrT     refTarget  [2**btbIdxW];
  // Back of the queue is the stack top
  addrT     refStack   [$];
  int       errCount = 0;

  clockGen clkGen (.clk(clk), .rstN(rstN));

  bpredTop i_bpredTop (.*);

  function automatic instrClassT decodeClass(instrT w);
    instrClassT c;
    c = '0;
    if (w[6:0] == 7'h67) begin
      // rs1 = ra marks a return
      if (w[19:15] == 5'd1) begin
        c[clsReturn] = 1'b1;
      end else begin
        c[clsJumpReg] = 1'b1;
      end
    end
    c[clsJump]   = (w[6:0] == 7'h6F);
    c[clsBranch] = (w[6:0] == 7'h63);
    return c;
  endfunction

  // Saturating step toward the outcome
  function automatic dirStateT stepCounter(dirStateT s, logic taken);
    case (s)
      strongNot: return taken ? weakNot : strongNot;
      weakNot:   return taken ? weakTaken : strongNot;
      weakTaken: return taken ? strongTaken : weakNot;
      default:   return taken ? strongTaken : weakTaken;
    endcase
  endfunction

  function automatic logic btbHit(addrT pc);
    btbIdxT i;
    i = pc[btbIdxW+1:2];
    return refValid[i] && (refPc[i][xlen-1:btbIdxW+2] == pc[xlen-1:btbIdxW+2]);
  endfunction

  function automatic logic expectWrong(instrClassT c, dirStateT st, logic taken,
                                       addrT target, addrT link, addrT pcDv);
    addrT correct;
    correct = taken ? target : link;
    if (c == '0) begin
      return 1'b0;
    end
    return (pcDv != correct) || (c[clsBranch] && (st[1] != taken));
  endfunction

  task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      errCount++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Prediction while the word sits on instrF, st is the counter read at lookup
  task automatic checkFetch(addrT pc, instrT w, dirStateT st);
    instrClassT c;
    logic       expSel;
    addrT       expPc;
    c = decodeClass(w);
    expPc = refTarget[pc[btbIdxW+1:2]];
    if (c[clsReturn]) begin
      expSel = 1'b1;
      expPc  = (refStack.size() == 0) ? '0 : refStack[$];
    end else if (c[clsJump] || c[clsJumpReg]) begin
      expSel = btbHit(pc);
    end else begin
      expSel = c[clsBranch] && btbHit(pc) && st[1];
    end
    #2;
    compareValue("selPredF", selPredF, expSel);
    if (expSel) begin
      compareValue("predPcF", predPcF, expPc);
    end
    // Return pops in fetch, an empty stack stays empty
    if (c[clsReturn] && (refStack.size() != 0)) begin
      void'(refStack.pop_back());
    end
  endtask

  // Training on the rising edge that ends an execute cycle
  task automatic applyUpdate(addrT pc, instrClassT c, dirStateT st, logic taken,
                             addrT target, addrT link);
    btbIdxT i;
    i = pc[btbIdxW+1:2];
    if (c[clsBranch]) begin
      refCounter[pc[dirIdxW+1:2]] = stepCounter(st, taken);
    end
    if (c[clsBranch] || c[clsJump] || c[clsJumpReg]) begin
      refValid[i]  = 1'b1;
      refPc[i]     = pc;
      refTarget[i] = target;
    end
    if (c[clsJump]) begin
      // Full stack loses its oldest entry
      if (refStack.size() == rasDepth) begin
        void'(refStack.pop_front());
      end
      refStack.push_back(link);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One instruction from lookup to execute
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue(addrT pc, instrT w, logic taken, addrT target, addrT pcDv,
                       int mode);
    instrClassT c;
    dirStateT   st;
    dirStateT   stX;
    addrT       link;
    int         eCycles;
    c       = (mode == modeFlush) ? '0 : decodeClass(w);
    link    = pc + 32'd4;
    eCycles = (mode == modeStall) ? 3 : 1;
    stX     = '0;

    // Lookup
    @(negedge clk);
    pcNextF = pc;
    instrF  = nopWord;
    st      = refCounter[pc[dirIdxW+1:2]];

    // Fetch
    @(negedge clk);
    pcNextF = '0;
    instrF  = w;
    checkFetch(pc, w, st);

    // Decode, flush here empties execute
    @(negedge clk);
    instrF = nopWord;
    flushD = (mode == modeFlush);

    // Execute inputs held steady through a stall
    for (int k = 0; k < eCycles; k++) begin
      @(negedge clk);
      flushD    = 1'b0;
      stallD    = (k < eCycles - 1);
      stallF    = stallD;
      pcNextF   = (mode == modeRefetch) ? pc : '0;
      pcE       = pc;
      pcTargetE = target;
      pcLinkE   = link;
      pcSrcE    = taken;
      pcD       = pcDv;
      // Counter read on the update edge sees the old value
      stX       = refCounter[pc[dirIdxW+1:2]];
      #2;
      compareValue("predWrongE", predWrongE, expectWrong(c, st, taken, target, link, pcDv));
      applyUpdate(pc, c, st, taken, target, link);
    end

    @(negedge clk);
    stallD    = 1'b0;
    stallF    = 1'b0;
    pcNextF   = '0;
    pcE       = '0;
    pcTargetE = '0;
    pcLinkE   = '0;
    pcSrcE    = 1'b0;
    pcD       = '0;
    if (mode == modeRefetch) begin
      // Forwarded target shows, the refetched word is flushed
      instrF = w;
      flushF = 1'b1;
      checkFetch(pc, w, stX);
      @(negedge clk);
      instrF = nopWord;
      flushF = 1'b0;
    end
  endtask

  // Watchdog
  initial begin
    #((numIssues * cyclesPerIssue + marginCycles) * 10);
    $display("Timeout: the scenarios did not finish within the cycle budget");
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    addrT  pc;
    addrT  target;
    addrT  pcDv;
    addrT  top;
    instrT w;
    logic  taken;
    void'($urandom(32'hb069f478));
    stallF    = 1'b0;
    stallD    = 1'b0;
    flushF    = 1'b0;
    flushD    = 1'b0;
    pcNextF   = '0;
    instrF    = nopWord;
    pcD       = '0;
    pcE       = '0;
    pcTargetE = '0;
    pcLinkE   = '0;
    pcSrcE    = 1'b0;
    for (int i = 0; i < 2**dirIdxW; i++) begin
      refCounter[i] = weakNot;
    end
    for (int i = 0; i < 2**btbIdxW; i++) begin
      refValid[i] = 1'b0;
    end
    wait (rstN === 1'b1);

    // Cold lookups miss, flushed in decode so the buffer stays empty
    pc = $urandom() & 32'hFFFF_FFFC;
    issue(pc, brWord, 1'b0, pc + 32'h20, pc + 32'd4, modeFlush);
    pc = $urandom() & 32'hFFFF_FFFC;
    issue(pc, jalWord, 1'b1, pc + 32'h80, pc + 32'h80, modeFlush);
    pc = $urandom() & 32'hFFFF_FFFC;
    issue(pc, jalrWord, 1'b1, pc + 32'h40, pc + 32'h40, modeFlush);

    // Branch trained taken, predicted, then trained back
    for (int n = 0; n < 3; n++) begin
      issue(32'h0000_1000, brWord, 1'b1, 32'h0000_2000, 32'h0000_2000, modePlain);
    end
    for (int n = 0; n < 3; n++) begin
      issue(32'h0000_1000, brWord, 1'b0, 32'h0000_2000, 32'h0000_1004, modePlain);
    end

    // Jump misses once, then hits with a wrong pcD
    issue(32'h0000_3010, jalWord, 1'b1, 32'h0000_3400, 32'h0000_3400, modePlain);
    issue(32'h0000_3010, jalWord, 1'b1, 32'h0000_3400, 32'h0000_3408, modePlain);
    // Fresh entry seen through forwarding
    issue(32'h0000_5020, jalrWord, 1'b1, 32'h0000_5800, 32'h0000_5800, modeRefetch);
    // Target moved, old prediction is wrong
    issue(32'h0000_5020, jalrWord, 1'b1, 32'h0000_5900, 32'h0000_5800, modePlain);

    // Five calls on a four-entry stack
    for (int n = 0; n < 5; n++) begin
      pc = 32'h0000_6004 + n * 32'h100;
      issue(pc, jalWord, 1'b1, pc + 32'h40, pc + 32'h40, modePlain);
    end
    // LIFO returns, the last one finds the stack empty
    for (int n = 0; n < 5; n++) begin
      top = (refStack.size() == 0) ? '0 : refStack[$];
      issue(32'h0000_7000 + n * 32'h10, retWord, 1'b1, top, top, modePlain);
    end

    // Stall in execute, flush in decode, then a lookup
    issue(32'h0000_1000, brWord, 1'b1, 32'h0000_2000, 32'h0000_2000, modeStall);
    issue(32'h0000_1000, brWord, 1'b0, 32'h0000_2000, 32'h0000_1004, modeFlush);
    issue(32'h0000_1000, brWord, 1'b0, 32'h0000_2000, 32'h0000_1004, modePlain);

    // Random mix
    for (int n = 0; n < 6; n++) begin
      pc = $urandom() & 32'hFFFF_FFFC;
      case ($urandom() % 4)
        0: w = brWord;
        1: w = jalWord;
        2: w = jalrWord;
        default: w = retWord;
      endcase
      taken  = (w == brWord) ? $urandom() % 2 : 1'b1;
      target = $urandom() & 32'hFFFF_FFFC;
      pcDv   = (($urandom() % 2) != 0) ? (taken ? target : pc + 32'd4) : target ^ 32'h10;
      issue(pc, w, taken, target, pcDv, $urandom() % 4);
    end

    repeat (3) @(negedge clk);
    $display("Checks done: %0d value errors, %0d assertion failures",
             errCount, i_bpredTop.chk.failCount);
    if ((errCount == 0) && (i_bpredTop.chk.failCount == 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/bpredChecker.sv ====
`timescale 1ns/1ps

module bpredChecker (
  input logic                      clk,
  input logic                      rstN,
  input logic                      stallD,
  input logic                      flushD,
  input logic                      selPredF,
  input logic                      predWrongE,
  input bpredTypesPkg::instrClassT classF,
  input bpredTypesPkg::instrClassT classE,
  input bpredTypesPkg::dirStateT   stateE
);
  import bpredTypesPkg::*;

  // Number of failed assertions
  int   failCount = 0;
  // Set once the buffer has taken its first write
  logic btbWritten;

  // Any class that stores a target writes the buffer on this edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      btbWritten <= 1'b0;
    end else if (classE[clsBranch] || classE[clsJump] || classE[clsJumpReg]) begin
      btbWritten <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reset and first lookup
  ////////////////////////////////////////////////////////////////////////////

  // Execute is empty right after a reset edge
  assert property (@(posedge clk) !rstN |=> (classE == '0) && !predWrongE)
    else begin
      $error("Execute stage not empty after reset");
      failCount++;
    end

  // Buffer still empty, only a return may redirect
  assert property (@(posedge clk) disable iff (!rstN)
                   !btbWritten && selPredF |-> classF[clsReturn])
    else begin
      $error("Prediction taken from an empty buffer after reset");
      failCount++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Execute stage rules
  ////////////////////////////////////////////////////////////////////////////

  // A misprediction needs a classed instruction in execute
  assert property (@(posedge clk) disable iff (!rstN) predWrongE |-> (classE != '0))
    else begin
      $error("Misprediction flagged with an empty execute stage");
      failCount++;
    end

  // Stalled execute keeps class and counter state
  assert property (@(posedge clk) disable iff (!rstN)
                   stallD && !flushD |=> $stable(classE) && $stable(stateE))
    else begin
      $error("Execute stage changed under a stall");
      failCount++;
    end

  // Flush empties execute, so nothing trains
  assert property (@(posedge clk) disable iff (!rstN)
                   flushD |=> (classE == '0) && !predWrongE)
    else begin
      $error("Execute stage not cleared by a flush");
      failCount++;
    end

endmodule

bind bpredTop bpredChecker chk (
  .clk(clk), .rstN(rstN), .stallD(stallD), .flushD(flushD),
  .selPredF(selPredF), .predWrongE(predWrongE), .classF(classF),
  .classE(resolve.classE), .stateE(resolve.stateE)
);

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rstN
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset over two rising edges, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// ==== design/bpredTop.sv ====
`timescale 1ns/1ps

module bpredTop (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stallF,
  input  logic                 stallD,
  input  logic                 flushF,
  input  logic                 flushD,
  input  bpredTypesPkg::addrT  pcNextF,
  input  bpredTypesPkg::instrT instrF,
  input  bpredTypesPkg::addrT  pcD,
  input  bpredTypesPkg::addrT  pcE,
  input  bpredTypesPkg::addrT  pcTargetE,
  input  bpredTypesPkg::addrT  pcLinkE,
  input  logic                 pcSrcE,
  output bpredTypesPkg::addrT  predPcF,
  output logic                 selPredF,
  output logic                 predWrongE
);
  import bpredTypesPkg::*;

  instrClassT classF;
  dirStateT   stateF;
  addrT       targetF;
  addrT       rasTopF;
  logic       hitF;

  // Execute-stage training bus
  bpredUpdateIf updIf ();

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////////////////////

  instrClassDecode decodeF (.instrF(instrF), .classF(classF));

  dirCounterTable dirTable (
    .clk(clk), .rstN(rstN), .pcNextF(pcNextF), .upd(updIf.sink), .stateF(stateF)
  );

  branchTargetBuffer btb (
    .clk(clk), .rstN(rstN), .pcNextF(pcNextF), .upd(updIf.sink),
    .targetF(targetF), .hitF(hitF)
  );

  // A return seen in fetch pops straight away
  returnAddrStack ras (
    .clk(clk), .rstN(rstN), .popF(classF[clsReturn]), .upd(updIf.sink), .topF(rasTopF)
  );

  // Return always redirects, jumps need a hit, branches also need taken
  assign selPredF = classF[clsReturn] |
                    ((classF[clsJump] | classF[clsJumpReg]) & hitF) |
                    (classF[clsBranch] & hitF & stateF[1]);
  assign predPcF  = classF[clsReturn] ? rasTopF : targetF;

  // Decode and execute side
  predResolve resolve (
    .clk(clk), .rstN(rstN),
    .stallF(stallF), .stallD(stallD), .flushF(flushF), .flushD(flushD),
    .classF(classF), .stateF(stateF),
    .pcD(pcD), .pcE(pcE), .pcTargetE(pcTargetE), .pcLinkE(pcLinkE), .pcSrcE(pcSrcE),
    .upd(updIf.source), .predWrongE(predWrongE)
  );

endmodule

// ==== design/predResolve.sv ====
`timescale 1ns/1ps

module predResolve (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      stallF,
  input  logic                      stallD,
  input  logic                      flushF,
  input  logic                      flushD,
  input  bpredTypesPkg::instrClassT classF,
  input  bpredTypesPkg::dirStateT   stateF,
  input  bpredTypesPkg::addrT       pcD,
  input  bpredTypesPkg::addrT       pcE,
  input  bpredTypesPkg::addrT       pcTargetE,
  input  bpredTypesPkg::addrT       pcLinkE,
  input  logic                      pcSrcE,
  bpredUpdateIf.source              upd,
  output logic                      predWrongE
);
  import bpredTypesPkg::*;

  instrClassT classD;
  instrClassT classE;
  dirStateT   stateD;
  dirStateT   stateE;
  addrT       correctPcE;
  logic       pcWrongE;
  logic       dirWrongE;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch to decode and decode to execute registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      classD <= '0;
      stateD <= '0;
      classE <= '0;
      stateE <= '0;
    end else begin
      // Flush wins over stall
      if (flushF) begin
        classD <= '0;
        stateD <= '0;
      end else if (!stallF) begin
        classD <= classF;
        stateD <= stateF;
      end
      if (flushD) begin
        classE <= '0;
        stateE <= '0;
      end else if (!stallD) begin
        classE <= classD;
        stateE <= stateD;
      end
    end
  end

  // Training data straight from execute
  assign upd.pcE     = pcE;
  assign upd.targetE = pcTargetE;
  assign upd.linkE   = pcLinkE;
  assign upd.takenE  = pcSrcE;
  assign upd.classE  = classE;

  // One saturating step toward the resolved direction
  always_comb begin
    if (upd.takenE) begin
      upd.newStateE = (stateE == strongTaken) ? stateE : stateE + 2'd1;
    end else begin
      upd.newStateE = (stateE == strongNot) ? stateE : stateE - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Misprediction check
  ////////////////////////////////////////////////////////////////////////////

  assign correctPcE = pcSrcE ? pcTargetE : pcLinkE;
  // Decode already fetched from pcD
  assign pcWrongE   = (pcD != correctPcE);
  assign dirWrongE  = classE[clsBranch] & (stateE[1] ^ pcSrcE);
  assign predWrongE = (|classE) & (pcWrongE | dirWrongE);

endmodule

// ==== design/returnAddrStack.sv ====
`timescale 1ns/1ps

module returnAddrStack (
  input  logic                clk,
  input  logic                rstN,
  input  logic                popF,
  bpredUpdateIf.sink          upd,
  output bpredTypesPkg::addrT topF
);
  import bpredCfgPkg::*;
  import bpredTypesPkg::*;

  addrT                        stack [rasDepth];
  // Points at the current top entry
  logic [$clog2(rasDepth)-1:0] topPtr;
  logic [$clog2(rasDepth)-1:0] ptrPop;
  logic [$clog2(rasDepth)-1:0] ptrPush;
  logic [$clog2(rasDepth):0]   count;
  logic [$clog2(rasDepth):0]   cntPop;
  logic                        popOk;
  logic                        push;

  ////////////////////////////////////////////////////////////////////////////
  // Pop first, then push
  ////////////////////////////////////////////////////////////////////////////

  assign popOk   = popF && (count != '0);
  assign ptrPop  = popOk ? topPtr - 1'b1 : topPtr;
  assign cntPop  = popOk ? count - 1'b1 : count;
  assign push    = upd.classE[clsJump];
  // Wraps onto the oldest entry when full
  assign ptrPush = ptrPop + 1'b1;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      topPtr <= '0;
      count  <= '0;
    end else if (push) begin
      topPtr <= ptrPush;
      count  <= (cntPop == rasDepth) ? cntPop : cntPop + 1'b1;
    end else begin
      topPtr <= ptrPop;
      count  <= cntPop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack[ptrPush] <= upd.linkE;
    end
  end

  // Empty stack reads as zero
  assign topF = (count == '0) ? '0 : stack[topPtr];

endmodule

// ==== design/branchTargetBuffer.sv ====
`timescale 1ns/1ps

module branchTargetBuffer (
  input  logic                clk,
  input  logic                rstN,
  input  bpredTypesPkg::addrT pcNextF,
  bpredUpdateIf.sink          upd,
  output bpredTypesPkg::addrT targetF,
  output logic                hitF
);
  import bpredCfgPkg::*;
  import bpredTypesPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Direct-mapped entries
  ////////////////////////////////////////////////////////////////////////////

  logic [2**btbIdxW-1:0]   validMem;
  logic [xlen-1:btbIdxW+2] tagMem    [2**btbIdxW];
  addrT                    targetMem [2**btbIdxW];

  btbIdxT rdIdx;
  btbIdxT wrIdx;
  logic   wrEn;
  logic   fwdHit;

  assign rdIdx = pcNextF[btbIdxW+1:2];
  assign wrIdx = upd.pcE[btbIdxW+1:2];

  // Branches and both jump kinds store a target
  assign wrEn = upd.classE[clsBranch] | upd.classE[clsJump] | upd.classE[clsJumpReg];

  // Same index and tag as the lookup this cycle
  assign fwdHit = wrEn && (upd.pcE[xlen-1:2] == pcNextF[xlen-1:2]);

  // Valid bits and registered hit flag
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validMem <= '0;
      hitF     <= 1'b0;
    end else begin
      if (wrEn) begin
        validMem[wrIdx] <= 1'b1;
      end
      hitF <= fwdHit ||
              (validMem[rdIdx] && (tagMem[rdIdx] == pcNextF[xlen-1:btbIdxW+2]));
    end
  end

  // Tag and target arrays, plus the registered target read
  always_ff @(posedge clk) begin
    if (wrEn) begin
      tagMem[wrIdx]    <= upd.pcE[xlen-1:btbIdxW+2];
      targetMem[wrIdx] <= upd.targetE;
    end
    targetF <= fwdHit ? upd.targetE : targetMem[rdIdx];
  end

endmodule

// ==== design/dirCounterTable.sv ====
`timescale 1ns/1ps

module dirCounterTable (
  input  logic                    clk,
  input  logic                    rstN,
  input  bpredTypesPkg::addrT     pcNextF,
  bpredUpdateIf.sink              upd,
  output bpredTypesPkg::dirStateT stateF
);
  import bpredCfgPkg::*;
  import bpredTypesPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Counter storage
  ////////////////////////////////////////////////////////////////////////////

  dirStateT counters [2**dirIdxW];
  dirIdxT   rdIdx;
  dirIdxT   wrIdx;
  logic     wrEn;

  // Word-aligned PC, drop the low two bits
  assign rdIdx = pcNextF[dirIdxW+1:2];
  assign wrIdx = upd.pcE[dirIdxW+1:2];

  // Only conditional branches train the direction
  assign wrEn = upd.classE[clsBranch];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      // Every entry starts weakly not taken
      for (int i = 0; i < 2**dirIdxW; i++) begin
        counters[i] <= weakNot;
      end
      stateF <= weakNot;
    end else begin
      if (wrEn) begin
        counters[wrIdx] <= upd.newStateE;
      end
      // Registered read, lines up with instrF next cycle
      stateF <= counters[rdIdx];
    end
  end

endmodule

// ==== design/instrClassDecode.sv ====
`timescale 1ns/1ps

module instrClassDecode (
  input  bpredTypesPkg::instrT      instrF,
  output bpredTypesPkg::instrClassT classF
);
  import bpredTypesPkg::*;

  logic [6:0] opcode;
  logic [4:0] rs1;
  logic       isJalr;

  // Only the opcode and rs1 matter here
  assign opcode = instrF[6:0];
  assign rs1    = instrF[19:15];

  // JALR covers both return and indirect jump
  assign isJalr = (opcode == 7'h67);

  always_comb begin
    classF = '0;
    // Return is JALR through ra (x1)
    classF[clsReturn]  = isJalr && (rs1 == 5'd1);
    // Any other JALR is a plain indirect jump
    classF[clsJumpReg] = isJalr && (rs1 != 5'd1);
    // JAL
    classF[clsJump]    = (opcode == 7'h6F);
    // Conditional branch group
    classF[clsBranch]  = (opcode == 7'h63);
  end

endmodule

// ==== design/bpredUpdateIf.sv ====
`timescale 1ns/1ps

interface bpredUpdateIf;
  import bpredTypesPkg::*;

  // Address of the instruction in execute
  addrT       pcE;
  // Resolved branch or jump target
  addrT       targetE;
  // Fall-through address, pushed on a jump
  addrT       linkE;
  // Resolved direction
  logic       takenE;
  // Class of the instruction in execute, zero means no update
  instrClassT classE;
  // Counter value to write back
  dirStateT   newStateE;

  // Execute stage drives the training data
  modport source (
    output pcE, targetE, linkE, takenE, classE, newStateE
  );

  // Tables and stack consume it on the next rising edge
  modport sink (
    input pcE, targetE, linkE, takenE, classE, newStateE
  );
endinterface

// ==== design/bpredTypesPkg.sv ====
package bpredTypesPkg;
  import bpredCfgPkg::*;

  // Fetch and execute addresses
  typedef logic [xlen-1:0] addrT;

  // Raw 32-bit instruction word, compressed forms not handled
  typedef logic [31:0] instrT;

  ////////////////////////////////////////////////////////////////////////////
  // One-hot instruction class
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] instrClassT;
  localparam int clsReturn  = 3;
  localparam int clsJumpReg = 2;
  localparam int clsJump    = 1;
  localparam int clsBranch  = 0;

  // Two-bit saturating counter, bit 1 is the taken prediction
  typedef logic [1:0] dirStateT;
  localparam dirStateT strongNot   = 2'd0;
  localparam dirStateT weakNot     = 2'd1;
  localparam dirStateT weakTaken   = 2'd2;
  localparam dirStateT strongTaken = 2'd3;

  // Table indices
  typedef logic [dirIdxW-1:0] dirIdxT;
  typedef logic [btbIdxW-1:0] btbIdxT;
endpackage

// ==== design/bpredCfgPkg.sv ====
package bpredCfgPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizing of the branch prediction unit
  ////////////////////////////////////////////////////////////////////////////

  // Fetch address width
  localparam int xlen = 32;

  // Direction counter table, 64 entries
  localparam int dirIdxW = 6;

  // Branch target buffer, 32 entries
  localparam int btbIdxW = 5;

  // Return address stack entries, power of two so the pointer wraps
  localparam int rasDepth = 4;

endpackage
